// ==== hw/cab_cfg.svh ====
// bridge register map
// snac stick thresholds and port count
// core reset and coin pulse lengths
`ifndef CAB_CFG_SVH
`define CAB_CFG_SVH

// bridge addresses, matched exactly
`define CAB_ADDR_LIVES      32'h2000_0000
`define CAB_ADDR_DIFF       32'h3000_0000
`define CAB_ADDR_BONUS      32'h4000_0000
`define CAB_ADDR_DEMO       32'h5000_0000
`define CAB_ADDR_RESET      32'h8000_0000
`define CAB_ADDR_ENABLE     32'hF200_0000
`define CAB_ADDR_SNAC_CFG   32'hF700_0000

// left stick, 0x00 is up/left and 0xff is down/right
`define CAB_ANALOG_LOW      8'h40
`define CAB_ANALOG_HIGH     8'hC0

// adapter ports on the cartridge
`define CAB_NUM_SNAC        2

// lengths in clk_74a cycles
`define CAB_RESET_HOLD      64
`define CAB_COIN_PULSE      16

`endif

// ==== hw/cab_bus_pkg.sv ====
// bridge bus address and data types
// dip switch word
// decoded register select
package cab_bus_pkg;

    // bridge side, 32 bit address and data
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // dip word as the game sees it, bytes swapped
    typedef logic [15:0] dip_t;

    // one value per mapped register
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_LIVES,
        SEL_DIFF,
        SEL_BONUS,
        SEL_DEMO,
        SEL_RESET,
        SEL_ENABLE,
        SEL_SNAC_CFG
    } reg_sel_e;

endpackage

// ==== hw/cab_pad_pkg.sv ====
// controller button and stick types
// snac controller type and routing mode
// game control word
package cab_pad_pkg;

    // button map
    // 3:0 up down left right, 4 face a, 9 r1, 14 select, 15 start
    typedef logic [15:0] key_t;

    // 7:0 left x, 15:8 left y, upper half right stick
    typedef logic [31:0] joy_t;

    // zero means no snac controller
    typedef logic [4:0] snac_type_t;

    // who feeds player 1 and player 2
    typedef enum logic [1:0] {
        ROUTE_S1_P1    = 2'd0,
        ROUTE_S1_P2    = 2'd1,
        ROUTE_STRAIGHT = 2'd2,
        ROUTE_SWAPPED  = 2'd3
    } route_e;

    // up down left right fire start coin, msb first
    typedef logic [6:0] game_ctl_t;

endpackage

// ==== hw/cab_bridge_regs.sv ====
// bridge register file: address decode, settings and snac config
// combinational read mux, dip word, snac flags
`timescale 1ns/1ps
`include "cab_cfg.svh"

module cab_bridge_regs (
    input  logic                   clk_74a,
    input  logic                   arst_n,
    input  cab_bus_pkg::bus_addr_t bridge_addr,
    input  logic                   bridge_wr,
    input  cab_bus_pkg::bus_data_t bridge_wr_data,
    output cab_bus_pkg::bus_data_t bridge_rd_data,
    output cab_bus_pkg::dip_t      dipsw,
    output logic                   snac_active,
    output logic                   snac_analog,
    output cab_pad_pkg::route_e    route,
    output logic                   reset_toggle
);
    import cab_bus_pkg::*;
    import cab_pad_pkg::*;

    reg_sel_e   sel;
    logic [1:0] lives;
    logic [2:0] difficulty;
    logic [2:0] bonus;
    logic       demo_sounds;
    logic       snac_en;
    snac_type_t snac_type;
    dip_t       settings;

    ////////////////////////////////////////////////////////////
    // address decode, exact match only
    always_comb begin
        case (bridge_addr)
            `CAB_ADDR_LIVES:    sel = SEL_LIVES;
            `CAB_ADDR_DIFF:     sel = SEL_DIFF;
            `CAB_ADDR_BONUS:    sel = SEL_BONUS;
            `CAB_ADDR_DEMO:     sel = SEL_DEMO;
            `CAB_ADDR_RESET:    sel = SEL_RESET;
            `CAB_ADDR_ENABLE:   sel = SEL_ENABLE;
            `CAB_ADDR_SNAC_CFG: sel = SEL_SNAC_CFG;
            default:            sel = SEL_NONE;
        endcase
    end

    // write side, one strobe per register
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            lives        <= 2'd0;
            difficulty   <= 3'd0;
            bonus        <= 3'd0;
            demo_sounds  <= 1'b0;
            snac_en      <= 1'b0;
            snac_type    <= '0;
            route        <= ROUTE_S1_P1;
            reset_toggle <= 1'b0;
        end else if (bridge_wr) begin
            case (sel)
                SEL_LIVES:  lives       <= bridge_wr_data[1:0];
                SEL_DIFF:   difficulty  <= bridge_wr_data[2:0];
                SEL_BONUS:  bonus       <= bridge_wr_data[2:0];
                SEL_DEMO:   demo_sounds <= bridge_wr_data[0];
                SEL_ENABLE: snac_en     <= bridge_wr_data[0];
                // data is ignored, any write flips it
                SEL_RESET:  reset_toggle <= ~reset_toggle;
                SEL_SNAC_CFG: begin
                    snac_type <= bridge_wr_data[4:0];
                    route     <= route_e'(bridge_wr_data[9:8]);
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read back, only enable and snac config are visible
    always_comb begin
        case (sel)
            SEL_ENABLE:   bridge_rd_data = {31'd0, snac_en};
            SEL_SNAC_CFG: bridge_rd_data = {22'd0, route, 3'd0, snac_type};
            default:      bridge_rd_data = '0;
        endcase
    end

    // settings word, then byte swap for the game
    assign settings = {demo_sounds, 1'b0, lives, 6'd0, difficulty, bonus};
    assign dipsw    = {settings[7:0], settings[15:8]};

    // snac flags, computed here once for all ports
    assign snac_active = snac_en && (snac_type != 5'h00);
    assign snac_analog = (snac_type == 5'h12) || (snac_type == 5'h13);

endmodule

// ==== hw/pad_decode.sv ====
// one snac port: buttons registered,
// d-pad taken from the left stick for analog pads
`timescale 1ns/1ps
`include "cab_cfg.svh"

module pad_decode (
    input  logic              clk_74a,
    input  logic              arst_n,
    input  cab_pad_pkg::key_t snac_key,
    input  cab_pad_pkg::joy_t snac_joy,
    input  logic              snac_analog,
    output cab_pad_pkg::key_t decoded_key
);
    import cab_pad_pkg::*;

    logic [7:0] stick_x;
    logic [7:0] stick_y;
    key_t       next_key;

    // left stick only
    assign stick_x = snac_joy[7:0];
    assign stick_y = snac_joy[15:8];

    always_comb begin
        next_key = snac_key;
        if (snac_analog) begin
            // dead zone between the two thresholds
            next_key[0] = (stick_y < `CAB_ANALOG_LOW);
            next_key[1] = (stick_y > `CAB_ANALOG_HIGH);
            next_key[2] = (stick_x < `CAB_ANALOG_LOW);
            next_key[3] = (stick_x > `CAB_ANALOG_HIGH);
        end
    end

    // one cycle from snac input to decoded key
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            decoded_key <= '0;
        end else begin
            decoded_key <= next_key;
        end
    end

endmodule

// ==== hw/player_router.sv ====
// player 1 and 2 source select by routing mode
// game control word from player 1
// coin pulse stretcher on the select button
`timescale 1ns/1ps
`include "cab_cfg.svh"

module player_router (
    input  logic                   clk_74a,
    input  logic                   arst_n,
    input  cab_pad_pkg::key_t      cont1_key,
    input  cab_pad_pkg::key_t      cont2_key,
    input  cab_pad_pkg::key_t      pad_key [`CAB_NUM_SNAC],
    input  logic                   snac_active,
    input  cab_pad_pkg::route_e    route,
    output cab_pad_pkg::key_t      p1_controls,
    output cab_pad_pkg::key_t      p2_controls,
    output cab_pad_pkg::game_ctl_t game_controls
);
    import cab_pad_pkg::*;

    typedef enum logic {COIN_IDLE, COIN_PULSE} coin_state_e;

    localparam int CNT_W = $clog2(`CAB_COIN_PULSE);

    key_t             p1_next;
    key_t             p2_next;
    coin_state_e      coin_state;
    logic [CNT_W-1:0] coin_cnt;
    logic             sel_q;
    logic             sel_fall;

    ////////////////////////////////////////////////////////////
    // source select
    always_comb begin
        // pocket pads when snac is off
        p1_next = cont1_key;
        p2_next = cont2_key;
        if (snac_active) begin
            case (route)
                ROUTE_S1_P1: begin
                    p1_next = pad_key[0];
                    p2_next = cont1_key;
                end
                ROUTE_S1_P2: begin
                    p1_next = cont1_key;
                    p2_next = pad_key[0];
                end
                ROUTE_STRAIGHT: begin
                    p1_next = pad_key[0];
                    p2_next = pad_key[1];
                end
                ROUTE_SWAPPED: begin
                    p1_next = pad_key[1];
                    p2_next = pad_key[0];
                end
            endcase
        end
    end

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            p1_controls <= '0;
            p2_controls <= '0;
        end else begin
            p1_controls <= p1_next;
            p2_controls <= p2_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // coin stretcher
    // select released on player 1
    assign sel_fall = sel_q && !p1_controls[14];

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            sel_q      <= 1'b0;
            coin_state <= COIN_IDLE;
            coin_cnt   <= '0;
        end else begin
            // tracks every cycle so edges inside a pulse are lost
            sel_q <= p1_controls[14];
            case (coin_state)
                COIN_IDLE: begin
                    if (sel_fall) begin
                        coin_state <= COIN_PULSE;
                        coin_cnt   <= '0;
                    end
                end
                COIN_PULSE: begin
                    if (coin_cnt == CNT_W'(`CAB_COIN_PULSE - 1)) begin
                        coin_state <= COIN_IDLE;
                    end
                    coin_cnt <= coin_cnt + 1'b1;
                end
            endcase
        end
    end

    // up down left right fire start coin
    assign game_controls = {p1_controls[0], p1_controls[1], p1_controls[2],
                            p1_controls[3], p1_controls[4], p1_controls[15],
                            coin_state == COIN_PULSE};

endmodule

// ==== hw/reset_stretch.sv ====
// host reset toggle detect
// core reset held for a fixed cycle count
`timescale 1ns/1ps
`include "cab_cfg.svh"

module reset_stretch (
    input  logic clk_74a,
    input  logic arst_n,
    input  logic reset_toggle,
    output logic core_reset
);
    typedef enum logic {RST_IDLE, RST_HOLD} rst_state_e;

    localparam int CNT_W = $clog2(`CAB_RESET_HOLD);

    rst_state_e       state;
    logic [CNT_W-1:0] hold_cnt;
    logic             toggle_q;

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            state    <= RST_IDLE;
            hold_cnt <= '0;
            toggle_q <= 1'b0;
        end else begin
            // follows the toggle always, so a flip during hold is swallowed
            toggle_q <= reset_toggle;
            case (state)
                RST_IDLE: begin
                    if (reset_toggle != toggle_q) begin
                        state    <= RST_HOLD;
                        hold_cnt <= '0;
                    end
                end
                RST_HOLD: begin
                    // last hold cycle
                    if (hold_cnt == CNT_W'(`CAB_RESET_HOLD - 1)) begin
                        state <= RST_IDLE;
                    end
                    hold_cnt <= hold_cnt + 1'b1;
                end
            endcase
        end
    end

    // high for the whole hold state
    assign core_reset = (state == RST_HOLD);

endmodule

// ==== hw/pocket_cab_top.sv ====
// top level: bridge registers, snac pad decoders,
// player router and reset stretcher
`timescale 1ns/1ps
`include "cab_cfg.svh"

module pocket_cab_top (
    input  logic                   clk_74a,
    input  logic                   arst_n,
    input  cab_bus_pkg::bus_addr_t bridge_addr,
    input  logic                   bridge_wr,
    input  cab_bus_pkg::bus_data_t bridge_wr_data,
    input  cab_pad_pkg::key_t      cont1_key,
    input  cab_pad_pkg::key_t      cont2_key,
    input  cab_pad_pkg::key_t      snac_key [`CAB_NUM_SNAC],
    input  cab_pad_pkg::joy_t      snac_joy [`CAB_NUM_SNAC],
    output cab_bus_pkg::bus_data_t bridge_rd_data,
    output cab_bus_pkg::dip_t      dipsw,
    output cab_pad_pkg::key_t      p1_controls,
    output cab_pad_pkg::key_t      p2_controls,
    output cab_pad_pkg::game_ctl_t game_controls,
    output logic                   core_reset
);
    import cab_pad_pkg::*;

    logic   snac_active;
    logic   snac_analog;
    logic   reset_toggle;
    route_e route;
    key_t   pad_key [`CAB_NUM_SNAC];

    ////////////////////////////////////////////////////////////
    // host registers
    cab_bridge_regs u_regs (
        .clk_74a        (clk_74a),
        .arst_n         (arst_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .dipsw          (dipsw),
        .snac_active    (snac_active),
        .snac_analog    (snac_analog),
        .route          (route),
        .reset_toggle   (reset_toggle)
    );

    // one decoder per adapter port
    for (genvar i = 0; i < `CAB_NUM_SNAC; i++) begin : g_pad
        pad_decode u_pad (
            .clk_74a     (clk_74a),
            .arst_n      (arst_n),
            .snac_key    (snac_key[i]),
            .snac_joy    (snac_joy[i]),
            .snac_analog (snac_analog),
            .decoded_key (pad_key[i])
        );
    end

    ////////////////////////////////////////////////////////////
    // player outputs and game controls
    player_router u_router (
        .clk_74a       (clk_74a),
        .arst_n        (arst_n),
        .cont1_key     (cont1_key),
        .cont2_key     (cont2_key),
        .pad_key       (pad_key),
        .snac_active   (snac_active),
        .route         (route),
        .p1_controls   (p1_controls),
        .p2_controls   (p2_controls),
        .game_controls (game_controls)
    );

    // manual core reset
    reset_stretch u_rst (
        .clk_74a      (clk_74a),
        .arst_n       (arst_n),
        .reset_toggle (reset_toggle),
        .core_reset   (core_reset)
    );

endmodule

// ==== dv/cab_clk_gen.sv ====
// free running clk_74a for the testbench, 4 ns period
`timescale 1ns/1ps

module cab_clk_gen (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end
endmodule

// ==== dv/cab_assert.sv ====
// pulse length checks for core reset and coin
// quiet outputs while arst_n is low, bound into the top level
`timescale 1ns/1ps
`include "cab_cfg.svh"

module cab_assert (
    input logic                   clk_74a,
    input logic                   arst_n,
    input cab_pad_pkg::key_t      p1_controls,
    input cab_pad_pkg::key_t      p2_controls,
    input cab_pad_pkg::game_ctl_t game_controls,
    input logic                   core_reset
);
    int unsigned rst_len;
    int unsigned coin_len;

    // run length of each pulse, cleared when it drops
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            rst_len  <= 0;
            coin_len <= 0;
        end else begin
            rst_len  <= core_reset ? rst_len + 1 : 0;
            coin_len <= game_controls[0] ? coin_len + 1 : 0;
        end
    end

    a_reset_len: assert property (@(posedge clk_74a) disable iff (!arst_n)
        $fell(core_reset) |-> rst_len == `CAB_RESET_HOLD)
        else $error("core_reset lasted %0d cycles", rst_len);

    a_coin_len: assert property (@(posedge clk_74a) disable iff (!arst_n)
        $fell(game_controls[0]) |-> coin_len == `CAB_COIN_PULSE)
        else $error("coin pulse lasted %0d cycles", coin_len);

    // nothing leaves the core while held in reset
    a_quiet_reset: assert property (@(posedge clk_74a)
        !arst_n |-> (p1_controls == '0 && p2_controls == '0 &&
                     game_controls == '0 && !core_reset))
        else $error("control output high during reset");
endmodule

bind pocket_cab_top cab_assert u_assert (
    .clk_74a       (clk_74a),
    .arst_n        (arst_n),
    .p1_controls   (p1_controls),
    .p2_controls   (p2_controls),
    .game_controls (game_controls),
    .core_reset    (core_reset)
);

// ==== dv/pocket_cab_tb.sv ====
// testbench for pocket_cab_top
// register readback, dip word, pocket and snac routing
// stick decode, coin pulse, core reset
`timescale 1ns/1ps
`include "cab_cfg.svh"

module pocket_cab_tb;
    import cab_bus_pkg::*;
    import cab_pad_pkg::*;

    logic      clk_74a;
    logic      arst_n;
    bus_addr_t bridge_addr;
    logic      bridge_wr;
    bus_data_t bridge_wr_data;
    key_t      cont1_key;
    key_t      cont2_key;
    key_t      snac_key [`CAB_NUM_SNAC];
    joy_t      snac_joy [`CAB_NUM_SNAC];
    bus_data_t bridge_rd_data;
    dip_t      dipsw;
    key_t      p1_controls;
    key_t      p2_controls;
    game_ctl_t game_controls;
    logic      core_reset;

    integer     seed;
    // reference copy of the host registers
    logic [1:0] m_lives;
    logic [2:0] m_diff;
    logic [2:0] m_bonus;
    logic       m_demo;
    logic       m_en;
    snac_type_t m_type;
    logic [1:0] m_route;

    cab_clk_gen u_clk (.clk (clk_74a));

    pocket_cab_top uut (
        .clk_74a        (clk_74a),
        .arst_n         (arst_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .cont1_key      (cont1_key),
        .cont2_key      (cont2_key),
        .snac_key       (snac_key),
        .snac_joy       (snac_joy),
        .bridge_rd_data (bridge_rd_data),
        .dipsw          (dipsw),
        .p1_controls    (p1_controls),
        .p2_controls    (p2_controls),
        .game_controls  (game_controls),
        .core_reset     (core_reset)
    );

    ////////////////////////////////////////////////////////////
    // failure reporting and compares
    task automatic report_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_dip(input string name, input dip_t exp, input dip_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_key(input string name, input key_t exp, input key_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_game(input string name, input game_ctl_t exp, input game_ctl_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            report_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    function automatic void apply_write(input bus_addr_t addr, input bus_data_t data);
        case (addr)
            `CAB_ADDR_LIVES:  m_lives = data[1:0];
            `CAB_ADDR_DIFF:   m_diff  = data[2:0];
            `CAB_ADDR_BONUS:  m_bonus = data[2:0];
            `CAB_ADDR_DEMO:   m_demo  = data[0];
            `CAB_ADDR_ENABLE: m_en    = data[0];
            `CAB_ADDR_SNAC_CFG: begin
                m_type  = data[4:0];
                m_route = data[9:8];
            end
            default: ;
        endcase
    endfunction

    function automatic bus_data_t expected_read(input bus_addr_t addr);
        bus_data_t d;
        d = '0;
        if (addr == `CAB_ADDR_ENABLE) begin
            d[0] = m_en;
        end else if (addr == `CAB_ADDR_SNAC_CFG) begin
            d[4:0] = m_type;
            d[9:8] = m_route;
        end
        return d;
    endfunction

    // high byte carries difficulty and bonus, low byte demo and lives
    function automatic dip_t expected_dip();
        return {2'b00, m_diff, m_bonus, m_demo, 1'b0, m_lives, 4'b0000};
    endfunction

    function automatic key_t decode_pad(input key_t key, input joy_t joy);
        key_t k;
        k = key;
        if (m_type == 5'h12 || m_type == 5'h13) begin
            k[0] = joy[15:8] < `CAB_ANALOG_LOW;
            k[1] = joy[15:8] > `CAB_ANALOG_HIGH;
            k[2] = joy[7:0] < `CAB_ANALOG_LOW;
            k[3] = joy[7:0] > `CAB_ANALOG_HIGH;
        end
        return k;
    endfunction

    task automatic route_players(output key_t p1, output key_t p2);
        key_t s1;
        key_t s2;
        s1 = decode_pad(snac_key[0], snac_joy[0]);
        s2 = decode_pad(snac_key[1], snac_joy[1]);
        p1 = cont1_key;
        p2 = cont2_key;
        if (m_en && m_type != 5'h00) begin
            p1 = (m_route == ROUTE_S1_P2) ? cont1_key : (m_route == ROUTE_SWAPPED) ? s2 : s1;
            p2 = (m_route == ROUTE_S1_P1) ? cont1_key : (m_route == ROUTE_STRAIGHT) ? s2 : s1;
        end
    endtask

    // up down left right fire start, then coin
    function automatic game_ctl_t game_word(input key_t k, input logic coin);
        return {k[0], k[1], k[2], k[3], k[4], k[15], coin};
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus helpers for the falling edge
    function automatic bus_data_t next_random();
        return $random(seed);
    endfunction

    function automatic snac_type_t digital_type();
        bus_data_t r;
        snac_type_t t;
        r = next_random();
        t = r[4:0];
        if (t == 5'h00 || t == 5'h12 || t == 5'h13) begin
            t = 5'h01;
        end
        return t;
    endfunction

    // thresholds and their neighbours now and then
    function automatic logic [7:0] stick_value();
        bus_data_t r;
        r = next_random();
        case (r[11:8])
            4'd0:    return 8'h3F;
            4'd1:    return `CAB_ANALOG_LOW;
            4'd2:    return `CAB_ANALOG_HIGH;
            4'd3:    return 8'hC1;
            default: return r[7:0];
        endcase
    endfunction

    task automatic next_cycle();
        @(negedge clk_74a);
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        bridge_addr    = addr;
        bridge_wr      = 1'b1;
        bridge_wr_data = data;
        next_cycle();
        bridge_wr = 1'b0;
        apply_write(addr, data);
    endtask

    task automatic check_read(input bus_addr_t addr);
        bridge_addr = addr;
        #1;
        check_data("bridge_rd_data", expected_read(addr), bridge_rd_data);
        next_cycle();
    endtask

    // fresh buttons and sticks on every snac port
    task automatic drive_snac(input logic analog);
        bus_data_t r;
        for (int p = 0; p < `CAB_NUM_SNAC; p++) begin
            r = next_random();
            snac_key[p] = r[15:0];
            snac_joy[p] = next_random();
            if (analog) begin
                snac_joy[p][7:0]  = stick_value();
                snac_joy[p][15:8] = stick_value();
            end
        end
    endtask

    task automatic drive_random(input logic analog);
        bus_data_t r;
        r = next_random();
        cont1_key = r[15:0];
        cont2_key = r[31:16];
        drive_snac(analog);
    endtask

    // wait until core reset and coin are both low
    task automatic wait_idle();
        int n;
        n = 0;
        while (core_reset || game_controls[0]) begin
            if (n == 200) begin
                $display("core_reset or coin pulse still high after 200 cycles");
                report_failure();
            end
            next_cycle();
            n++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // behaviors
    task automatic regs_readback();
        bus_data_t r;
        bus_addr_t other;
        for (int i = 0; i < 24; i++) begin
            r = next_random();
            other = next_random();
            case (r[1:0])
                2'd0:       bus_write(`CAB_ADDR_ENABLE, next_random());
                2'd1, 2'd2: bus_write(`CAB_ADDR_SNAC_CFG, next_random());
                default:    bus_write(other, next_random());
            endcase
            check_read(`CAB_ADDR_ENABLE);
            check_read(`CAB_ADDR_SNAC_CFG);
            check_read(other);
        end
    endtask

    task automatic dip_word();
        bus_data_t r;
        bus_addr_t a;
        for (int i = 0; i < 16; i++) begin
            r = next_random();
            case (r[1:0])
                2'd0:    a = `CAB_ADDR_LIVES;
                2'd1:    a = `CAB_ADDR_DIFF;
                2'd2:    a = `CAB_ADDR_BONUS;
                default: a = `CAB_ADDR_DEMO;
            endcase
            bus_write(a, next_random());
            check_dip("dipsw", expected_dip(), dipsw);
            // settings are write only and read back as zero
            check_read(a);
        end
    endtask

    task automatic pocket_passthrough();
        bus_data_t r;
        key_t      e1;
        key_t      e2;
        for (int i = 0; i < 6; i++) begin
            r = next_random();
            // snac off by a clear enable, or enabled with type zero
            bus_write(`CAB_ADDR_ENABLE, {31'd0, ~r[0]});
            bus_write(`CAB_ADDR_SNAC_CFG, r[0] ? r : (r & 32'hFFFF_FFE0));
            for (int c = 0; c < 8; c++) begin
                drive_random(1'b0);
                route_players(e1, e2);
                next_cycle();
                check_key("p1_controls", e1, p1_controls);
                check_key("p2_controls", e2, p2_controls);
            end
        end
    endtask

    task automatic snac_routing(input logic analog);
        bus_data_t cfg;
        bus_data_t r;
        key_t      e1;
        key_t      e2;
        for (int rt = 0; rt < 4; rt++) begin
            r = next_random();
            cfg = '0;
            cfg[9:8] = rt[1:0];
            // analog pads are type 0x12 and 0x13
            cfg[4:0] = analog ? {4'h9, r[0]} : digital_type();
            bus_write(`CAB_ADDR_ENABLE, 32'd1);
            bus_write(`CAB_ADDR_SNAC_CFG, cfg);
            for (int i = 0; i < 8; i++) begin
                drive_random(analog);
                route_players(e1, e2);
                // pad decoder stage
                next_cycle();
                // newer snac data is still one stage behind
                drive_snac(analog);
                // router stage
                next_cycle();
                check_key("p1_controls", e1, p1_controls);
                check_key("p2_controls", e2, p2_controls);
            end
        end
    endtask

    task automatic coin_pulse();
        bus_data_t r;
        key_t      base;
        key_t      with_sel;
        key_t      exp_p1;
        logic      coin;
        r = next_random();
        base = r[15:0];
        base[14] = 1'b0;
        with_sel = base;
        with_sel[14] = 1'b1;
        bus_write(`CAB_ADDR_ENABLE, 32'd0);
        cont1_key = with_sel;
        next_cycle();
        wait_idle();
        next_cycle();
        next_cycle();
        // release select
        cont1_key = base;
        for (int c = 1; c <= `CAB_COIN_PULSE + 4; c++) begin
            exp_p1 = cont1_key;
            next_cycle();
            coin = (c >= 2 && c <= `CAB_COIN_PULSE + 1);
            check_key("p1_controls", exp_p1, p1_controls);
            check_game("game_controls", game_word(exp_p1, coin), game_controls);
            // a second press and release inside the pulse is ignored
            if (c == 2) begin
                cont1_key = with_sel;
            end
            if (c == 4) begin
                cont1_key = base;
            end
        end
    endtask

    task automatic reset_pulse();
        wait_idle();
        bus_write(`CAB_ADDR_RESET, next_random());
        for (int c = 1; c <= `CAB_RESET_HOLD + 6; c++) begin
            check_flag("core_reset", c >= 2 && c <= `CAB_RESET_HOLD + 1, core_reset);
            // second toggle lands inside the hold
            if (c == 8) begin
                bridge_addr = `CAB_ADDR_RESET;
                bridge_wr   = 1'b1;
            end
            if (c == 9) begin
                bridge_wr = 1'b0;
            end
            next_cycle();
        end
    endtask

    ////////////////////////////////////////////////////////////
    initial begin
        seed           = 32'hc30e_ace7;
        arst_n         = 1'b0;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        cont1_key      = '0;
        cont2_key      = '0;
        for (int p = 0; p < `CAB_NUM_SNAC; p++) begin
            snac_key[p] = '0;
            snac_joy[p] = '0;
        end
        m_lives = '0;
        m_diff  = '0;
        m_bonus = '0;
        m_demo  = 1'b0;
        m_en    = 1'b0;
        m_type  = '0;
        m_route = '0;
        repeat (2) @(negedge clk_74a);
        arst_n = 1'b1;

        // everything starts at zero
        check_key("p1_controls", '0, p1_controls);
        check_key("p2_controls", '0, p2_controls);
        check_game("game_controls", '0, game_controls);
        check_dip("dipsw", '0, dipsw);
        check_flag("core_reset", 1'b0, core_reset);
        check_read(`CAB_ADDR_SNAC_CFG);

        regs_readback();
        dip_word();
        pocket_passthrough();
        snac_routing(1'b0);
        snac_routing(1'b1);
        coin_pulse();
        reset_pulse();

        $display("=== PASS ===");
        $finish;
    end
endmodule

// ==== pocket_cab.f ====
+incdir+hw
hw/cab_bus_pkg.sv
hw/cab_pad_pkg.sv
hw/cab_bridge_regs.sv
hw/pad_decode.sv
hw/player_router.sv
hw/reset_stretch.sv
hw/pocket_cab_top.sv
dv/cab_clk_gen.sv
dv/cab_assert.sv
dv/pocket_cab_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the pocket_cab testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module pocket_cab_tb \
    -o pocket_cab_sim -f pocket_cab.f &&
./obj_dir/pocket_cab_sim | tee /dev/stderr | grep -qF "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
